// ==== Makefile ====
# Verilator build and run of the secmem testbench

VERILATOR ?= verilator
TOP       ?= tb_secmem
FLIST     ?= secmem.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass message in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS PASS_MSG"

$(SIM_BIN): $(FLIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dma_ctrl.sv ====
// single-word dma copy, reads the source then writes the destination
// both accesses carry the latched domain through the partition check

`timescale 1ns/1ps

`include "secmem_consts.svh"

module dma_ctrl (
	input  logic                  clk,
	input  logic                  rst,

	input  secmem_pkg::dma_cmd_t  cmd,
	input  logic                  domain,
	input  logic                  val,
	output logic                  rdy,
	output logic                  done,
	output logic                  fail,

	output secmem_pkg::mem_req_t  mem_req,
	output logic                  mem_domain,
	output logic                  mem_val,
	input  logic                  mem_rdy,

	input  secmem_pkg::mem_resp_t mem_resp,
	input  logic                  mem_resp_val,
	output logic                  mem_resp_rdy
);

	localparam logic [2:0] st_idle    = 3'd0;
	localparam logic [2:0] st_rd_req  = 3'd1;
	localparam logic [2:0] st_rd_wait = 3'd2;
	localparam logic [2:0] st_wr_req  = 3'd3;
	localparam logic [2:0] st_wr_wait = 3'd4;
	localparam logic [2:0] st_done    = 3'd5;

	// tags dma traffic in the opaque field
	localparam logic [`SECMEM_OPAQUE_NBITS-1:0] dma_tag = 8'hd0;

	logic [2:0]                   state;
	logic [`SECMEM_ADDR_NBITS-1:0] src_q;
	logic [`SECMEM_ADDR_NBITS-1:0] dest_q;
	logic [`SECMEM_DATA_NBITS-1:0] data_q;
	logic                          domain_q;
	logic                          fail_q;

	assign rdy          = (state == st_idle);
	assign done         = (state == st_done);
	assign fail         = fail_q;
	assign mem_domain   = domain_q;
	assign mem_val      = (state == st_rd_req) || (state == st_wr_req);
	assign mem_resp_rdy = (state == st_rd_wait) || (state == st_wr_wait);

	always_comb begin
		mem_req.opaque = dma_tag;
		if (state == st_wr_req) begin
			mem_req.msg_type = `SECMEM_TYPE_WRITE;
			mem_req.addr     = dest_q;
			mem_req.data     = data_q;
		end else begin
			mem_req.msg_type = `SECMEM_TYPE_READ;
			mem_req.addr     = src_q;
			mem_req.data     = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:    if (val) state <= st_rd_req;
				st_rd_req:  if (mem_rdy) state <= st_rd_wait;
				st_rd_wait: if (mem_resp_val) state <= mem_resp.fail ? st_done : st_wr_req;
				st_wr_req:  if (mem_rdy) state <= st_wr_wait;
				st_wr_wait: if (mem_resp_val) state <= st_done;
				default:    state <= st_idle;
			endcase
		end
	end

	// command latch and copy data
	always_ff @(posedge clk) begin
		if (state == st_idle && val) begin
			src_q    <= cmd.src_addr;
			dest_q   <= cmd.dest_addr;
			domain_q <= domain;
		end
		if (state == st_rd_wait && mem_resp_val) begin
			data_q <= mem_resp.data;
			fail_q <= mem_resp.fail;
		end
		if (state == st_wr_wait && mem_resp_val) begin
			fail_q <= mem_resp.fail;
		end
	end

endmodule

// ==== mem_addr_ctrl.sv ====
// address partition check in front of main memory
// allowed requests pass straight through, denied ones get a fail response

`timescale 1ns/1ps

`include "secmem_consts.svh"

module mem_addr_ctrl (
	input  logic                  clk,
	input  logic                  rst,

	input  secmem_pkg::mem_req_t  up_req,
	input  logic                  up_domain,
	input  logic                  up_val,
	output logic                  up_rdy,

	output secmem_pkg::mem_resp_t up_resp,
	output logic                  up_resp_val,
	input  logic                  up_resp_rdy,

	output secmem_pkg::mem_req_t  mem_req,
	output logic                  mem_val,
	input  logic                  mem_rdy,

	input  secmem_pkg::mem_resp_t mem_resp,
	input  logic                  mem_resp_val,
	output logic                  mem_resp_rdy,

	output logic                  violation
);

	import secmem_pkg::*;

	logic      allow;
	logic      deny_go;
	logic      fail_val_q;
	mem_resp_t fail_q;

	// secure domain sees everything
	assign allow = up_domain || (up_req.addr >= `SECMEM_PAR_ADDR);

	assign mem_req = up_req;
	assign mem_val = up_val && allow;

	assign up_rdy    = allow ? mem_rdy : !fail_val_q;
	assign deny_go   = up_val && !allow && !fail_val_q;
	assign violation = deny_go;

	//==============================
	// fail response register
	//==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			fail_val_q <= 1'b0;
		end else if (deny_go) begin
			fail_val_q <= 1'b1;
		end else if (up_resp_rdy) begin
			fail_val_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (deny_go) begin
			fail_q.msg_type <= up_req.msg_type;
			fail_q.opaque   <= up_req.opaque;
			fail_q.fail     <= 1'b1;
			fail_q.data     <= '0;
		end
	end

	// a pending fail response goes first
	assign up_resp      = fail_val_q ? fail_q : mem_resp;
	assign up_resp_val  = fail_val_q || mem_resp_val;
	assign mem_resp_rdy = up_resp_rdy && !fail_val_q;

endmodule

// ==== mem_arbiter.sv ====
// two-requester arbiter, cache on port 0 has priority over dma on port 1
// one request outstanding, the response returns to the recorded owner

`timescale 1ns/1ps

module mem_arbiter (
	input  logic                  clk,
	input  logic                  rst,

	input  secmem_pkg::mem_req_t  req0,
	input  logic                  req0_domain,
	input  logic                  req0_val,
	output logic                  req0_rdy,
	output secmem_pkg::mem_resp_t resp0,
	output logic                  resp0_val,
	input  logic                  resp0_rdy,

	input  secmem_pkg::mem_req_t  req1,
	input  logic                  req1_domain,
	input  logic                  req1_val,
	output logic                  req1_rdy,
	output secmem_pkg::mem_resp_t resp1,
	output logic                  resp1_val,
	input  logic                  resp1_rdy,

	output secmem_pkg::mem_req_t  req,
	output logic                  req_domain,
	output logic                  req_val,
	input  logic                  req_rdy,
	input  secmem_pkg::mem_resp_t resp,
	input  logic                  resp_val,
	output logic                  resp_rdy
);

	logic busy_q;
	logic owner_q;
	logic sel;
	logic req_go;
	logic resp_go;

	//==============================
	// request side
	//==============================

	// port 1 only when port 0 is idle
	assign sel = req1_val && !req0_val;

	assign req        = sel ? req1 : req0;
	assign req_domain = sel ? req1_domain : req0_domain;
	assign req_val    = !busy_q && (req0_val || req1_val);

	assign req0_rdy = !busy_q && req_rdy;
	assign req1_rdy = !busy_q && sel && req_rdy;

	assign req_go = req_val && req_rdy;

	//==============================
	// response side
	//==============================

	assign resp0     = resp;
	assign resp1     = resp;
	assign resp0_val = resp_val && busy_q && !owner_q;
	assign resp1_val = resp_val && busy_q && owner_q;
	assign resp_rdy  = owner_q ? resp1_rdy : resp0_rdy;

	assign resp_go = resp_val && resp_rdy && busy_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q  <= 1'b0;
			owner_q <= 1'b0;
		end else if (req_go) begin
			busy_q  <= 1'b1;
			owner_q <= sel;
		end else if (resp_go) begin
			busy_q  <= 1'b0;
		end
	end

endmodule

// ==== secmem.f ====
+incdir+.
secmem_pkg.sv
test_mem.sv
mem_addr_ctrl.sv
mem_arbiter.sv
dma_ctrl.sv
secmem_top.sv
tb_secmem.sv

// ==== secmem_consts.svh ====
// fixed widths, memory depth, partition boundary and opcodes for secmem
// included by the package and by any RTL file that needs a value

`ifndef SECMEM_CONSTS_SVH
`define SECMEM_CONSTS_SVH

// message field widths
`define SECMEM_ADDR_NBITS 32
`define SECMEM_DATA_NBITS 32
`define SECMEM_OPAQUE_NBITS 8

// main memory depth in words
`define SECMEM_MEM_NWORDS 256

// insecure domain may only touch byte addresses at or above this
`define SECMEM_PAR_ADDR 32'h0000_0200

// request and response kinds
`define SECMEM_TYPE_READ 3'd0
`define SECMEM_TYPE_WRITE 3'd1

`endif

// ==== secmem_pkg.sv ====
// message types of the secmem memory path
// shared by the RTL and the testbench

`include "secmem_consts.svh"

package secmem_pkg;

	typedef logic [2:0] mem_type_t;

	// memory request, 75 bits
	typedef struct packed {
		mem_type_t                        msg_type;
		logic [`SECMEM_OPAQUE_NBITS-1:0]  opaque;
		logic [`SECMEM_ADDR_NBITS-1:0]    addr;
		logic [`SECMEM_DATA_NBITS-1:0]    data;
	} mem_req_t;

	// dma command, same width as a request
	typedef struct packed {
		logic [10:0]                      pad;
		logic [`SECMEM_ADDR_NBITS-1:0]    src_addr;
		logic [`SECMEM_ADDR_NBITS-1:0]    dest_addr;
	} dma_cmd_t;

	// one request word, seen as a memory access or as a copy command
	typedef union packed {
		mem_req_t  req;
		dma_cmd_t  dma;
	} mem_req_u;

	// memory response, 44 bits
	typedef struct packed {
		mem_type_t                        msg_type;
		logic [`SECMEM_OPAQUE_NBITS-1:0]  opaque;
		logic                             fail;
		logic [`SECMEM_DATA_NBITS-1:0]    data;
	} mem_resp_t;

endpackage

// ==== secmem_top.sv ====
// secmem top level, cache and dma share one memory behind the partition check
// arbiter -> address control -> main memory, responses return the same way

`timescale 1ns/1ps

module secmem_top (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  mem_clear,

	input  secmem_pkg::mem_req_u  cache_req,
	input  logic                  cache_req_domain,
	input  logic                  cache_req_val,
	output logic                  cache_req_rdy,

	output secmem_pkg::mem_resp_t cache_resp,
	output logic                  cache_resp_val,
	input  logic                  cache_resp_rdy,

	input  secmem_pkg::mem_req_u  dma_cmd,
	input  logic                  dma_domain,
	input  logic                  dma_val,
	output logic                  dma_rdy,

	output logic                  dma_done,
	output logic                  dma_fail,

	output logic                  violation
);

	import secmem_pkg::*;

	// dma controller to arbiter
	mem_req_t  dma_req;
	logic      dma_req_domain;
	logic      dma_req_val;
	logic      dma_req_rdy;
	mem_resp_t dma_resp;
	logic      dma_resp_val;
	logic      dma_resp_rdy;

	// arbiter to address control
	mem_req_t  arb_req;
	logic      arb_req_domain;
	logic      arb_req_val;
	logic      arb_req_rdy;
	mem_resp_t arb_resp;
	logic      arb_resp_val;
	logic      arb_resp_rdy;

	// address control to memory
	mem_req_t  mem_req;
	logic      mem_req_val;
	logic      mem_req_rdy;
	mem_resp_t mem_resp;
	logic      mem_resp_val;
	logic      mem_resp_rdy;

	dma_ctrl dma (
		.clk          (clk),
		.rst          (rst),
		.cmd          (dma_cmd.dma),
		.domain       (dma_domain),
		.val          (dma_val),
		.rdy          (dma_rdy),
		.done         (dma_done),
		.fail         (dma_fail),
		.mem_req      (dma_req),
		.mem_domain   (dma_req_domain),
		.mem_val      (dma_req_val),
		.mem_rdy      (dma_req_rdy),
		.mem_resp     (dma_resp),
		.mem_resp_val (dma_resp_val),
		.mem_resp_rdy (dma_resp_rdy)
	);

	mem_arbiter arb (
		.clk         (clk),
		.rst         (rst),
		.req0        (cache_req.req),
		.req0_domain (cache_req_domain),
		.req0_val    (cache_req_val),
		.req0_rdy    (cache_req_rdy),
		.resp0       (cache_resp),
		.resp0_val   (cache_resp_val),
		.resp0_rdy   (cache_resp_rdy),
		.req1        (dma_req),
		.req1_domain (dma_req_domain),
		.req1_val    (dma_req_val),
		.req1_rdy    (dma_req_rdy),
		.resp1       (dma_resp),
		.resp1_val   (dma_resp_val),
		.resp1_rdy   (dma_resp_rdy),
		.req         (arb_req),
		.req_domain  (arb_req_domain),
		.req_val     (arb_req_val),
		.req_rdy     (arb_req_rdy),
		.resp        (arb_resp),
		.resp_val    (arb_resp_val),
		.resp_rdy    (arb_resp_rdy)
	);

	mem_addr_ctrl addr_ctrl (
		.clk          (clk),
		.rst          (rst),
		.up_req       (arb_req),
		.up_domain    (arb_req_domain),
		.up_val       (arb_req_val),
		.up_rdy       (arb_req_rdy),
		.up_resp      (arb_resp),
		.up_resp_val  (arb_resp_val),
		.up_resp_rdy  (arb_resp_rdy),
		.mem_req      (mem_req),
		.mem_val      (mem_req_val),
		.mem_rdy      (mem_req_rdy),
		.mem_resp     (mem_resp),
		.mem_resp_val (mem_resp_val),
		.mem_resp_rdy (mem_resp_rdy),
		.violation    (violation)
	);

	test_mem mem (
		.clk       (clk),
		.rst       (rst),
		.mem_clear (mem_clear),
		.req       (mem_req),
		.req_val   (mem_req_val),
		.req_rdy   (mem_req_rdy),
		.resp      (mem_resp),
		.resp_val  (mem_resp_val),
		.resp_rdy  (mem_resp_rdy)
	);

endmodule

// ==== tb_secmem.sv ====
// testbench for secmem_top, runs a table of cache and dma operations
// expected values come from a shadow memory, run it through the Makefile

`timescale 1ns/1ps

`include "secmem_consts.svh"

module tb_secmem;

	import secmem_pkg::*;

	localparam int clk_period = 100;
	localparam int drive_dly  = 1;
	localparam int idx_nbits  = $clog2(`SECMEM_MEM_NWORDS);

	localparam logic [1:0] op_wr   = 2'd0;
	localparam logic [1:0] op_rd   = 2'd1;
	localparam logic [1:0] op_dma  = 2'd2;
	localparam logic [1:0] op_conc = 2'd3;

	typedef struct {
		logic [1:0]  op;
		logic        dom;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] data;
		logic        rnd;
		int          stall;
		logic        exp_fail;
	} op_t;

	logic      clk;
	logic      rst;
	logic      mem_clear;
	mem_req_u  cache_req;
	logic      cache_req_domain;
	logic      cache_req_val;
	logic      cache_req_rdy;
	mem_resp_t cache_resp;
	logic      cache_resp_val;
	logic      cache_resp_rdy;
	mem_req_u  dma_cmd;
	logic      dma_domain;
	logic      dma_val;
	logic      dma_rdy;
	logic      dma_done;
	logic      dma_fail;
	logic      violation;

	op_t         tbl [$];
	logic [31:0] shadow [0:`SECMEM_MEM_NWORDS-1];
	logic [31:0] lfsr_q = 32'd97274;
	int          cycles = 0;
	int          cycle_limit = 100;
	int          viol_count = 0;

	secmem_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$fatal(1, "run stopped by timeout");
		end
	end

	// one count per denied access
	always @(negedge clk) begin
		if (!rst && violation) begin
			viol_count <= viol_count + 1;
		end
	end

	//==============================
	// helpers and checks
	//==============================

	task automatic stop_with_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic rand_word(output logic [31:0] w);
		w = '0;
		for (int n = 0; n < 32; n++) begin
			lfsr_q = next_lfsr(lfsr_q);
			w = {w[30:0], lfsr_q[0]};
		end
	endtask

	// byte address over 4, modulo the depth
	function automatic logic [idx_nbits-1:0] word_idx(input logic [31:0] addr);
		return addr[idx_nbits+1:2];
	endfunction

	function automatic mem_resp_t make_resp(input mem_type_t typ, input logic [7:0] opq,
			input logic f, input logic [31:0] d);
		mem_resp_t r;
		r.msg_type = typ;
		r.opaque   = opq;
		r.fail     = f;
		r.data     = d;
		return r;
	endfunction

	task automatic check_resp(input mem_resp_t got, input mem_resp_t exp, input string what);
		if (got !== exp) begin
			stop_with_error($sformatf(
				"%s: got type %0d opq %h fail %b data %h, exp type %0d opq %h fail %b data %h",
				what, got.msg_type, got.opaque, got.fail, got.data,
				exp.msg_type, exp.opaque, exp.fail, exp.data));
		end
	endtask

	task automatic check_dma(input logic done_next, input logic fail, input logic exp_fail);
		if (done_next !== 1'b0) begin
			stop_with_error("dma_done stayed high for more than one cycle");
		end
		if (fail !== exp_fail) begin
			stop_with_error($sformatf("dma_fail is %b, expected %b", fail, exp_fail));
		end
	endtask

	task automatic check_violation(input int exp);
		if (viol_count != exp) begin
			stop_with_error($sformatf("%0d violation pulses, expected %0d", viol_count, exp));
		end
	endtask

	//==============================
	// bus drivers
	//==============================

	task automatic cache_access(input mem_type_t typ, input logic dom, input logic [31:0] addr,
			input logic [31:0] data, input logic [7:0] opq, input int stall,
			output mem_resp_t resp);
		mem_req_u  u;
		mem_resp_t first;
		u = '0;
		u.req.msg_type   = typ;
		u.req.opaque     = opq;
		u.req.addr       = addr;
		u.req.data       = data;
		cache_req        = u;
		cache_req_domain = dom;
		cache_req_val    = 1'b1;
		@(negedge clk);
		while (!cache_req_rdy) @(negedge clk);
		@(posedge clk);
		#drive_dly;
		cache_req_val  = 1'b0;
		cache_resp_rdy = (stall == 0);
		@(negedge clk);
		while (!cache_resp_val) @(negedge clk);
		first = cache_resp;
		// held response must stay put
		for (int held = 0; held < stall; held++) begin
			@(posedge clk);
			#drive_dly;
			if (held == stall - 1) begin
				cache_resp_rdy = 1'b1;
			end
			@(negedge clk);
			if (!cache_resp_val || cache_resp !== first) begin
				stop_with_error("cache response changed while cache_resp_rdy was low");
			end
		end
		resp = cache_resp;
		@(posedge clk);
		#drive_dly;
	endtask

	task automatic dma_copy(input logic dom, input logic [31:0] src, input logic [31:0] dest,
			output logic done_next, output logic fail);
		mem_req_u u;
		u = '0;
		u.dma.src_addr  = src;
		u.dma.dest_addr = dest;
		dma_cmd    = u;
		dma_domain = dom;
		dma_val    = 1'b1;
		@(negedge clk);
		while (!dma_rdy) @(negedge clk);
		@(posedge clk);
		#drive_dly;
		dma_val = 1'b0;
		@(negedge clk);
		while (!dma_done) @(negedge clk);
		fail = dma_fail;
		// done is a single-cycle pulse
		@(negedge clk);
		done_next = dma_done;
		@(posedge clk);
		#drive_dly;
	endtask

	//==============================
	// stimulus table
	//==============================

	task automatic add_op(input logic [1:0] op, input logic dom, input logic [31:0] a,
			input logic [31:0] b, input logic [31:0] c, input logic [31:0] data,
			input logic rnd, input int stall, input logic exp_fail);
		op_t e;
		e = '{op, dom, a, b, c, data, rnd, stall, exp_fail};
		tbl.push_back(e);
	endtask

	task automatic load_table();
		// op, domain, addr or source, dest, reads beside a copy, data, random, stall, fail
		add_op(op_rd,   1'b1, 32'h000, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		add_op(op_rd,   1'b1, 32'h150, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		add_op(op_rd,   1'b1, 32'h3fc, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		// above the boundary, both domains
		add_op(op_wr,   1'b0, 32'h204, 32'h000, 32'h000, 32'h0,         1'b1, 0, 1'b0);
		add_op(op_rd,   1'b0, 32'h204, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		add_op(op_wr,   1'b1, 32'h300, 32'h000, 32'h000, 32'hcafe_f00d, 1'b0, 0, 1'b0);
		add_op(op_rd,   1'b1, 32'h300, 32'h000, 32'h000, 32'h0,         1'b0, 3, 1'b0);
		add_op(op_wr,   1'b0, 32'h208, 32'h000, 32'h000, 32'h0,         1'b1, 0, 1'b0);
		add_op(op_wr,   1'b1, 32'h040, 32'h000, 32'h000, 32'h0,         1'b1, 0, 1'b0);
		add_op(op_rd,   1'b1, 32'h040, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		// insecure below the boundary
		add_op(op_wr,   1'b0, 32'h040, 32'h000, 32'h000, 32'hdead_beef, 1'b0, 0, 1'b1);
		add_op(op_rd,   1'b0, 32'h040, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b1);
		add_op(op_rd,   1'b0, 32'h1fc, 32'h000, 32'h000, 32'h0,         1'b0, 2, 1'b1);
		add_op(op_rd,   1'b1, 32'h040, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		// dma copies
		add_op(op_dma,  1'b1, 32'h204, 32'h100, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		add_op(op_rd,   1'b1, 32'h100, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		add_op(op_dma,  1'b0, 32'h300, 32'h20c, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		add_op(op_rd,   1'b0, 32'h20c, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		add_op(op_dma,  1'b0, 32'h040, 32'h208, 32'h000, 32'h0,         1'b0, 0, 1'b1);
		add_op(op_dma,  1'b0, 32'h300, 32'h100, 32'h000, 32'h0,         1'b0, 0, 1'b1);
		add_op(op_rd,   1'b1, 32'h208, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		add_op(op_rd,   1'b1, 32'h100, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
		// copy with cache traffic and held responses
		add_op(op_conc, 1'b1, 32'h300, 32'h044, 32'h204, 32'h0,         1'b0, 4, 1'b0);
		add_op(op_rd,   1'b1, 32'h044, 32'h000, 32'h000, 32'h0,         1'b0, 0, 1'b0);
	endtask

	//==============================
	// main sequence
	//==============================

	initial begin
		op_t                  e;
		mem_resp_t            got;
		mem_resp_t            got2;
		logic [31:0]          wdata;
		logic [7:0]           opq;
		logic [idx_nbits-1:0] ia;
		logic                 done_next;
		logic                 fail;
		int                   exp_viol;

		rst              = 1'b1;
		mem_clear        = 1'b0;
		cache_req        = '0;
		cache_req_domain = 1'b0;
		cache_req_val    = 1'b0;
		cache_resp_rdy   = 1'b1;
		dma_cmd          = '0;
		dma_domain       = 1'b0;
		dma_val          = 1'b0;
		shadow           = '{default: '0};
		exp_viol         = 0;
		load_table();
		cycle_limit = tbl.size() * 20 + 100;

		repeat (2) @(posedge clk);
		#drive_dly;
		rst = 1'b0;
		@(negedge clk);
		if (cache_req_rdy !== 1'b1 || dma_rdy !== 1'b1 || cache_resp_val !== 1'b0
				|| dma_done !== 1'b0 || violation !== 1'b0) begin
			stop_with_error("handshake outputs not at their idle values after reset");
		end
		@(posedge clk);
		#drive_dly;
		mem_clear = 1'b1;
		@(posedge clk);
		#drive_dly;
		mem_clear = 1'b0;

		foreach (tbl[k]) begin
			e     = tbl[k];
			opq   = 8'(k);
			ia    = word_idx(e.a);
			wdata = e.data;
			if (e.rnd) begin
				rand_word(wdata);
			end
			case (e.op)
				op_wr: begin
					cache_access(`SECMEM_TYPE_WRITE, e.dom, e.a, wdata, opq, e.stall, got);
					check_resp(got, make_resp(`SECMEM_TYPE_WRITE, opq, e.exp_fail, 32'h0),
						"cache write");
					if (!e.exp_fail) begin
						shadow[ia] = wdata;
					end
				end
				op_rd: begin
					cache_access(`SECMEM_TYPE_READ, e.dom, e.a, 32'h0, opq, e.stall, got);
					check_resp(got, make_resp(`SECMEM_TYPE_READ, opq, e.exp_fail,
						e.exp_fail ? 32'h0 : shadow[ia]), "cache read");
				end
				op_dma: begin
					dma_copy(e.dom, e.a, e.b, done_next, fail);
					check_dma(done_next, fail, e.exp_fail);
					if (!e.exp_fail) begin
						shadow[word_idx(e.b)] = shadow[ia];
					end
				end
				default: begin
					// reads stay clear of the copy destination
					fork
						dma_copy(e.dom, e.a, e.b, done_next, fail);
						begin
							@(posedge clk);
							#drive_dly;
							cache_access(`SECMEM_TYPE_READ, 1'b1, e.c, 32'h0, opq, e.stall, got);
							check_resp(got, make_resp(`SECMEM_TYPE_READ, opq, 1'b0,
								shadow[word_idx(e.c)]), "first read during copy");
							cache_access(`SECMEM_TYPE_READ, 1'b1, e.c + 32'd4, 32'h0,
								opq ^ 8'h80, e.stall, got2);
							check_resp(got2, make_resp(`SECMEM_TYPE_READ, opq ^ 8'h80, 1'b0,
								shadow[word_idx(e.c + 32'd4)]), "second read during copy");
						end
					join
					check_dma(done_next, fail, e.exp_fail);
					if (!e.exp_fail) begin
						shadow[word_idx(e.b)] = shadow[ia];
					end
				end
			endcase
			if (e.exp_fail) begin
				exp_viol++;
			end
			check_violation(exp_viol);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== test_mem.sv ====
// word-addressed main memory with a one-entry response register
// mem_clear zeroes every word while high

`timescale 1ns/1ps

`include "secmem_consts.svh"

module test_mem (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  mem_clear,

	input  secmem_pkg::mem_req_t  req,
	input  logic                  req_val,
	output logic                  req_rdy,

	output secmem_pkg::mem_resp_t resp,
	output logic                  resp_val,
	input  logic                  resp_rdy
);

	localparam int idx_nbits = $clog2(`SECMEM_MEM_NWORDS);

	logic [`SECMEM_DATA_NBITS-1:0] mem [0:`SECMEM_MEM_NWORDS-1];

	logic                 req_go;
	logic                 is_write;
	logic [idx_nbits-1:0] idx;

	// byte address to word index, wraps at the depth
	assign idx      = req.addr[2 +: idx_nbits];
	assign is_write = (req.msg_type == `SECMEM_TYPE_WRITE);

	// take a new request when the response slot is free or draining
	assign req_rdy = !resp_val || resp_rdy;
	assign req_go  = req_val && req_rdy;

	always_ff @(posedge clk) begin
		if (mem_clear) begin
			for (int i = 0; i < `SECMEM_MEM_NWORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (req_go && is_write) begin
			mem[idx] <= req.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_val <= 1'b0;
		end else if (req_go) begin
			resp_val <= 1'b1;
		end else if (resp_rdy) begin
			resp_val <= 1'b0;
		end
	end

	// writes answer with zero data
	always_ff @(posedge clk) begin
		if (req_go) begin
			resp.msg_type <= req.msg_type;
			resp.opaque   <= req.opaque;
			resp.fail     <= 1'b0;
			resp.data     <= is_write ? '0 : mem[idx];
		end
	end

endmodule
